//--- Bender.yml
package:
  name: dcache

sources:
  - hw/dcache_pkg.sv
  - hw/dcache_arrays.sv
  - hw/dcache_plru.sv
  - hw/dcache_ctrl.sv
  - hw/dcache_top.sv
  - target: simulation
    files:
      - dv/dcache_properties.sv
      - dv/dcache_tb.sv

//--- dv/dcache_properties.sv
// top-level handshakes only, nothing about data or replacement, all checks off during reset
`timescale 1ns/1ns

module dcache_properties (
    input logic                clk,
    input logic                reset,
    input logic                req_valid,
    input logic                busy,
    input logic                done,
    input logic                mem_rd_req,
    input logic                mem_rd_rdy,
    input dcache_pkg::addr_t   mem_rd_addr,
    input logic                mem_wr_req,
    input logic                mem_wr_rdy,
    input dcache_pkg::addr_t   mem_wr_addr
);
    int fail_cnt = 0;

    // one memory transfer at a time
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_req && mem_wr_req))
        else begin
            $error("read and write requests high together");
            fail_cnt++;
        end

    rd_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req && !mem_rd_rdy |=> mem_rd_req && $stable(mem_rd_addr))
        else begin
            $error("read request dropped or moved before rdy");
            fail_cnt++;
        end

    wr_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req && !mem_wr_rdy |=> mem_wr_req && $stable(mem_wr_addr))
        else begin
            $error("write request dropped or moved before rdy");
            fail_cnt++;
        end

    // a second done in a row needs a request accepted with the first
    done_single: assert property (@(posedge clk) disable iff (reset)
        done && !(req_valid && !busy) |=> !done)
        else begin
            $error("done repeated with no new request accepted");
            fail_cnt++;
        end

endmodule

bind dcache_top dcache_properties props_i (.*);

//--- dv/dcache_tb.sv
// memory model starts with each word equal to its address, waits are capped at 200 cycles
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    logic clk, reset, req_valid, busy, done;
    mem_op_t req_op;
    addr_t req_addr, mem_rd_addr, mem_wr_addr;
    word_t req_wdata, rdata;
    wstrb_t req_wstrb;
    logic mem_rd_req, mem_rd_rdy, mem_ret_valid, mem_wr_req, mem_wr_rdy, mem_wr_done;
    line_t mem_ret_data, mem_wr_data;

    int seed = 83;
    int cycle = 0, last_latency = 0, rd_count = 0, wr_count = 0, rd_base, wr_base;
    int word_errs = 0, line_errs = 0, count_errs = 0, other_errs = 0, assert_errs;
    logic wb_open = 1'b0;           // writeback accepted, done not yet seen
    logic [7:0] shadow [addr_t];    // per byte, stores only
    line_t mem_lines [addr_t];      // lines written back
    mem_op_t exp_op [$];            // one entry per accepted request
    word_t exp_word [$];
    int exp_cyc [$];

    dcache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end
    always @(posedge clk) cycle <= cycle + 1;

    function automatic int rand_delay();
        return {$random(seed)} % 4;  // 0 to 3 cycles
    endfunction

    function automatic addr_t make_addr(input int tag, input int set, input int word);
        return {tag[23:0], set[3:0], word[1:0], 2'b00};
    endfunction

    function automatic line_t default_line(input addr_t a);
        line_t l;
        for (int i = 0; i < LINE_WORD_NUM; i++) l[i*32 +: 32] = {a[31:4], 4'h0} + 4 * i;
        return l;
    endfunction

    // reference model, untouched bytes read back as their word address
    function automatic word_t expected_load(input addr_t addr);
        addr_t wa;
        word_t w;
        wa = {addr[31:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = shadow.exists(wa + b) ? shadow[wa + b]
                                                : wa[b*8 +: 8];
        end
        return w;
    endfunction

    function automatic line_t shadow_line(input addr_t a);
        line_t l;
        for (int i = 0; i < LINE_WORD_NUM; i++) begin
            l[i*32 +: 32] = expected_load({a[31:4], 4'h0} + 4 * i);
        end
        return l;
    endfunction

    task automatic merge_store(input addr_t addr, input word_t wdata, input wstrb_t wstrb);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) shadow[{addr[31:2], 2'b00} + b] = wdata[b*8 +: 8];
        end
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            word_errs++;
            $display("FAILED %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            line_errs++;
            $display("FAILED %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errs++;
            $display("FAILED %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout after 200 cycles: %s", what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    // present a request and return once it is accepted, at 1 ns after the edge
    task automatic issue(input mem_op_t op, input addr_t addr, input word_t wdata,
                         input wstrb_t wstrb);
        int t;
        t = 0;
        req_valid = 1'b1;
        req_op = op;
        req_addr = addr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        @(negedge clk);
        while (busy && t < 200) begin
            t++;
            @(negedge clk);
        end
        if (busy) begin
            timeout_abort("request not accepted");
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    // queue is sampled on the rising edge, away from the negedge pops
    task automatic finish_all();
        int t;
        t = 0;
        req_valid = 1'b0;
        do begin
            @(posedge clk);
            t++;
        end while (exp_op.size() != 0 && t < 200);
        if (exp_op.size() != 0) begin
            timeout_abort("accepted request never completed");
        end else begin
            #1;
        end
    endtask

    task automatic load(input addr_t addr);
        issue(OP_LOAD, addr, '0, '0);
        finish_all();
    endtask

    // compare process, everything sampled at the falling edge
    initial begin : compare_proc
        mem_op_t op;
        word_t ew;
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (done && exp_op.size() == 0) begin
                    other_errs++;
                    $display("done pulsed at %0t with no request outstanding", $time);
                end else if (done) begin
                    op = exp_op.pop_front();
                    ew = exp_word.pop_front();
                    last_latency = cycle - exp_cyc.pop_front();
                    if (op == OP_LOAD) compare_word("rdata", rdata, ew);
                end
                if (req_valid && !busy) begin  // accepted at the next edge
                    if (req_op == OP_STORE) merge_store(req_addr, req_wdata, req_wstrb);
                    exp_op.push_back(req_op);
                    exp_word.push_back(expected_load(req_addr));
                    exp_cyc.push_back(cycle);
                end
                if (mem_rd_req && mem_rd_rdy) begin
                    rd_count++;
                    if (wb_open) begin
                        other_errs++;
                        $display("refill read at %0t before writeback finished", $time);
                    end
                end
                if (mem_wr_req && mem_wr_rdy) begin
                    wr_count++;
                    wb_open = 1'b1;
                    compare_line("mem_wr_data", mem_wr_data, shadow_line(mem_wr_addr));
                end
                if (mem_wr_done) wb_open = 1'b0;
            end
        end
    end

    initial begin : mem_read_model
        addr_t a;
        forever begin
            @(negedge clk);
            if (mem_rd_req) begin
                a = mem_rd_addr;
                @(posedge clk);
                #1;
                repeat (rand_delay()) begin
                    @(posedge clk);
                    #1;
                end
                mem_rd_rdy = 1'b1;
                @(posedge clk);
                #1 mem_rd_rdy = 1'b0;
                repeat (rand_delay()) begin
                    @(posedge clk);
                    #1;
                end
                mem_ret_data = mem_lines.exists(a) ? mem_lines[a] : default_line(a);
                mem_ret_valid = 1'b1;  // one-cycle return strobe
                @(posedge clk);
                #1 mem_ret_valid = 1'b0;
            end
        end
    end

    initial begin : mem_write_model
        forever begin
            @(negedge clk);
            if (mem_wr_req) begin
                mem_lines[mem_wr_addr] = mem_wr_data;  // held stable until rdy
                @(posedge clk);
                #1;
                repeat (rand_delay()) begin
                    @(posedge clk);
                    #1;
                end
                mem_wr_rdy = 1'b1;
                @(posedge clk);
                #1 mem_wr_rdy = 1'b0;
                repeat (rand_delay()) begin
                    @(posedge clk);
                    #1;
                end
                mem_wr_done = 1'b1;
                @(posedge clk);
                #1 mem_wr_done = 1'b0;
            end
        end
    end

    initial begin : stimulus
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = OP_LOAD;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        mem_rd_rdy = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data = '0;
        mem_wr_rdy = 1'b0;
        mem_wr_done = 1'b0;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        compare_count("busy", busy, 0);
        compare_count("done", done, 0);
        compare_count("mem_rd_req", mem_rd_req, 0);
        compare_count("mem_wr_req", mem_wr_req, 0);
        @(posedge clk);
        #1;
        rd_base = rd_count;  // cold miss
        load(32'h0000_0104);
        compare_count("reads on cold miss", rd_count - rd_base, 1);
        rd_base = rd_count;  // same line again
        load(32'h0000_0108);
        compare_count("reads on hit", rd_count - rd_base, 0);
        compare_count("hit latency", last_latency, 1);
        // mixed strobes, back to back
        issue(OP_STORE, 32'h0000_0104, 32'hdead_beef, 4'b0101);
        issue(OP_LOAD, 32'h0000_0104, '0, '0);
        issue(OP_STORE, 32'h0000_010c, 32'h1234_5678, 4'b1100);
        issue(OP_LOAD, 32'h0000_010c, '0, '0);
        finish_all();
        for (int i = 0; i < 4; i++) load(make_addr(16 + i, 1, 0));  // A to D in set 1
        rd_base = rd_count;
        load(make_addr(20, 1, 0));  // E evicts A
        compare_count("reads for E", rd_count - rd_base, 1);
        rd_base = rd_count;
        load(make_addr(17, 1, 1));
        compare_count("reads for B", rd_count - rd_base, 0);
        load(make_addr(16, 1, 2));
        compare_count("reads for A", rd_count - rd_base, 1);
        issue(OP_STORE, make_addr(32, 2, 1), 32'hcafe_f00d, 4'b1111);  // dirty way 0
        finish_all();
        for (int i = 1; i < 4; i++) load(make_addr(32 + i, 2, 0));
        rd_base = rd_count;
        wr_base = wr_count;
        load(make_addr(36, 2, 3));  // victim is the dirty line
        compare_count("writebacks on dirty eviction", wr_count - wr_base, 1);
        compare_count("reads on dirty eviction", rd_count - rd_base, 1);
        load(make_addr(32, 2, 1));  // stored word comes back from memory
        for (int n = 0; n < 150; n++) begin
            issue(({$random(seed)} % 2) ? OP_STORE : OP_LOAD,
                  make_addr(48 + {$random(seed)} % 6, 3 + {$random(seed)} % 3,
                            {$random(seed)} % 4),
                  $random(seed), wstrb_t'($random(seed)));
        end
        finish_all();
        assert_errs = dut_i.props_i.fail_cnt;
        $display("errors: word %0d, line %0d, count %0d, other %0d, assertion %0d",
                 word_errs, line_errs, count_errs, other_errs, assert_errs);
        if (word_errs + line_errs + count_errs + other_errs + assert_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- hw/dcache_arrays.sv
// reads are combinational from rd_index and a refill and a store never hit the same way in one cycle
`timescale 1ns/1ns

module dcache_arrays (
    input  logic                                            clk,
    input  logic                                            reset,
    input  dcache_pkg::index_t                              rd_index,
    input  dcache_pkg::index_t                              wr_index,
    input  dcache_pkg::way_t                                refill_we,
    input  dcache_pkg::tag_t                                refill_tag,
    input  dcache_pkg::line_t                               refill_line,
    input  dcache_pkg::way_t                                store_we,
    input  dcache_pkg::word_sel_t                           store_word,
    input  dcache_pkg::word_t                               store_wdata,
    input  dcache_pkg::wstrb_t                              store_wstrb,
    output dcache_pkg::way_t                                way_valid,
    output dcache_pkg::way_t                                way_dirty,
    output dcache_pkg::tag_t  [dcache_pkg::ASSOC_NUM-1:0]   way_tags,
    output dcache_pkg::line_t [dcache_pkg::ASSOC_NUM-1:0]   way_lines
);
    import dcache_pkg::*;

    way_t                   valid_q [SET_NUM];
    way_t                   dirty_q [SET_NUM];
    tag_t [ASSOC_NUM-1:0]   tag_q   [SET_NUM];
    word_t                  data_mem [ASSOC_NUM][SET_NUM][LINE_WORD_NUM];  // plain RAM

    // valid, dirty and tags live in flops
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SET_NUM; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                tag_q[s]   <= '0;
            end
        end else begin
            for (int w = 0; w < ASSOC_NUM; w++) begin
                if (refill_we[w]) begin
                    valid_q[wr_index][w] <= 1'b1;
                    dirty_q[wr_index][w] <= 1'b0;  // fresh line is clean
                    tag_q[wr_index][w]   <= refill_tag;
                end else if (store_we[w]) begin
                    dirty_q[wr_index][w] <= 1'b1;
                end
            end
        end
    end

    // data words, whole line on refill, byte merge on store
    always_ff @(posedge clk) begin
        for (int w = 0; w < ASSOC_NUM; w++) begin
            if (refill_we[w]) begin
                for (int i = 0; i < LINE_WORD_NUM; i++) begin
                    data_mem[w][wr_index][i] <= refill_line[i*WORD_WIDTH +: WORD_WIDTH];
                end
            end else if (store_we[w]) begin
                for (int b = 0; b < WORD_WIDTH/8; b++) begin
                    if (store_wstrb[b]) begin  // untouched bytes keep old data
                        data_mem[w][wr_index][store_word][b*8 +: 8] <= store_wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    // async read of the addressed set, all ways at once
    always_comb begin
        way_valid = valid_q[rd_index];
        way_dirty = dirty_q[rd_index];
        way_tags  = tag_q[rd_index];
        for (int w = 0; w < ASSOC_NUM; w++) begin
            for (int i = 0; i < LINE_WORD_NUM; i++) begin
                way_lines[w][i*WORD_WIDTH +: WORD_WIDTH] = data_mem[w][rd_index][i];
            end
        end
    end

endmodule

//--- hw/dcache_ctrl.sv
// CPU holds its request while busy and memory returns mem_wr_done and mem_ret_valid after rdy
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            req_valid,
    input  dcache_pkg::mem_op_t                             req_op,
    input  dcache_pkg::addr_t                               req_addr,
    input  dcache_pkg::word_t                               req_wdata,
    input  dcache_pkg::wstrb_t                              req_wstrb,
    input  logic                                            mem_rd_rdy,
    input  logic                                            mem_ret_valid,
    input  dcache_pkg::line_t                               mem_ret_data,
    input  logic                                            mem_wr_rdy,
    input  logic                                            mem_wr_done,
    input  dcache_pkg::way_t                                way_valid,
    input  dcache_pkg::way_t                                way_dirty,
    input  dcache_pkg::tag_t  [dcache_pkg::ASSOC_NUM-1:0]   way_tags,
    input  dcache_pkg::line_t [dcache_pkg::ASSOC_NUM-1:0]   way_lines,
    input  dcache_pkg::way_idx_t                            victim,
    output logic                                            busy,
    output logic                                            done,
    output dcache_pkg::word_t                               rdata,
    output logic                                            mem_rd_req,
    output dcache_pkg::addr_t                               mem_rd_addr,
    output logic                                            mem_wr_req,
    output dcache_pkg::addr_t                               mem_wr_addr,
    output dcache_pkg::line_t                               mem_wr_data,
    output dcache_pkg::index_t                              rd_index,
    output dcache_pkg::index_t                              wr_index,
    output dcache_pkg::way_t                                refill_we,
    output dcache_pkg::tag_t                                refill_tag,
    output dcache_pkg::line_t                               refill_line,
    output dcache_pkg::way_t                                store_we,
    output dcache_pkg::word_sel_t                           store_word,
    output dcache_pkg::word_t                               store_wdata,
    output dcache_pkg::wstrb_t                              store_wstrb,
    output dcache_pkg::index_t                              access_index,
    output dcache_pkg::way_idx_t                            access_way,
    output logic                                            access_en
);
    import dcache_pkg::*;

    miss_state_t state_q, state_d;

    logic      req_vld_q;  // request in compare stage
    mem_op_t   op_q;
    addr_t     addr_q;
    word_t     wdata_q;
    wstrb_t    wstrb_q;

    tag_t      tag_q;
    index_t    index_q;
    word_sel_t word_q;
    way_t      hit;
    logic      hit_any;
    way_idx_t  hit_idx;
    way_t      victim_oh;
    logic      victim_dirty;

    // address fields of the held request
    assign tag_q   = addr_q[$bits(addr_t)-1 -: TAG_WIDTH];
    assign index_q = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign word_q  = addr_q[OFFSET_WIDTH-1 -: $bits(word_sel_t)];

    // accept whenever not busy, a hit frees the stage in its compare cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            req_vld_q <= 1'b0;
        end else if (!busy) begin
            req_vld_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && !busy) begin
            op_q    <= req_op;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
    end

    // tag compare on the set read this cycle
    always_comb begin
        hit     = '0;
        hit_idx = '0;
        for (int w = 0; w < ASSOC_NUM; w++) begin
            hit[w] = way_valid[w] && (way_tags[w] == tag_q);
            if (hit[w]) begin
                hit_idx = way_idx_t'(w);
            end
        end
    end
    assign hit_any = |hit;

    // selected word of the hitting way
    always_comb begin
        rdata = '0;
        for (int w = 0; w < ASSOC_NUM; w++) begin
            if (hit[w]) begin
                rdata = rdata | way_lines[w][word_q*WORD_WIDTH +: WORD_WIDTH];
            end
        end
    end

    assign victim_oh    = way_t'(1) << victim;
    assign victim_dirty = way_valid[victim] && way_dirty[victim];  // only valid lines need writeback

    assign done = (state_q == LOOKUP) && req_vld_q && hit_any;
    assign busy = (state_q != LOOKUP) || (req_vld_q && !hit_any);  // miss raises it in compare cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (req_vld_q && !hit_any) begin
                    state_d = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: if (mem_wr_rdy) state_d = WRITEBACK;
            WRITEBACK: if (mem_wr_done) state_d = MISS_CLEAN;  // refill waits for the write
            MISS_CLEAN: if (mem_rd_rdy) state_d = REFILL;
            REFILL: if (mem_ret_valid) state_d = REFILL_DONE;
            REFILL_DONE: state_d = LOOKUP;  // recompare now hits
            default: state_d = LOOKUP;
        endcase
    end

    // memory side, held until rdy since set and victim do not move
    assign mem_wr_req  = (state_q == MISS_DIRTY);
    assign mem_wr_addr = {way_tags[victim], index_q, {OFFSET_WIDTH{1'b0}}};
    assign mem_wr_data = way_lines[victim];
    assign mem_rd_req  = (state_q == MISS_CLEAN);
    assign mem_rd_addr = {tag_q, index_q, {OFFSET_WIDTH{1'b0}}};

    // array writes, both at the held index
    assign rd_index    = index_q;
    assign wr_index    = index_q;
    assign refill_we   = (state_q == REFILL && mem_ret_valid) ? victim_oh : '0;
    assign refill_tag  = tag_q;
    assign refill_line = mem_ret_data;  // written straight from the return beat
    assign store_we    = (done && op_q == OP_STORE) ? hit : '0;
    assign store_word  = word_q;
    assign store_wdata = wdata_q;
    assign store_wstrb = wstrb_q;

    // replacement update on every completed access
    assign access_index = index_q;
    assign access_way   = hit_idx;
    assign access_en    = done;

endmodule

//--- hw/dcache_pkg.sv
// sizes are fixed for a 32-bit address, 16 sets of 4 ways and 16-byte lines
package dcache_pkg;

    localparam int ASSOC_NUM     = 4;   // ways
    localparam int SET_NUM       = 16;
    localparam int LINE_WORD_NUM = 4;   // words per line
    localparam int WORD_WIDTH    = 32;
    localparam int OFFSET_WIDTH  = 4;   // byte offset in line
    localparam int INDEX_WIDTH   = 4;
    localparam int TAG_WIDTH     = 24;
    localparam int PLRU_BITS     = 3;   // tree bits per set

    typedef logic [31:0]                           addr_t;
    typedef logic [WORD_WIDTH-1:0]                 word_t;
    typedef logic [WORD_WIDTH/8-1:0]               wstrb_t;
    // word 0 sits in the low bits
    typedef logic [LINE_WORD_NUM*WORD_WIDTH-1:0]   line_t;
    typedef logic [TAG_WIDTH-1:0]                  tag_t;
    typedef logic [INDEX_WIDTH-1:0]                index_t;
    typedef logic [$clog2(LINE_WORD_NUM)-1:0]      word_sel_t;
    typedef logic [ASSOC_NUM-1:0]                  way_t;      // one-hot
    typedef logic [$clog2(ASSOC_NUM)-1:0]          way_idx_t;  // binary

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } mem_op_t;

    // miss sequencing, LOOKUP is the idle/compare state
    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,   // writeback request out
        WRITEBACK,    // waiting for write done
        MISS_CLEAN,   // refill read request out
        REFILL,       // waiting for line return
        REFILL_DONE   // one cycle for the write to land
    } miss_state_t;

endpackage

//--- hw/dcache_plru.sv
// tree layout is fixed for 4 ways and victim is combinational for access_index only
`timescale 1ns/1ns

module dcache_plru (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::index_t     access_index,
    input  dcache_pkg::way_idx_t   access_way,
    input  logic                   access_en,
    output dcache_pkg::way_idx_t   victim
);
    import dcache_pkg::*;

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    logic [PLRU_BITS-1:0] tree_q [SET_NUM];
    logic [PLRU_BITS-1:0] cur;

    assign cur = tree_q[access_index];

    // 0 points to the lower way
    always_comb begin
        if (cur[0] == 1'b0) begin
            victim = {1'b0, cur[1]};
        end else begin
            victim = {1'b1, cur[2]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SET_NUM; s++) begin
                tree_q[s] <= '0;  // victim starts at way 0
            end
        end else if (access_en) begin
            tree_q[access_index][0] <= ~access_way[1];  // root away from used half
            if (access_way[1] == 1'b0) begin
                tree_q[access_index][1] <= ~access_way[0];
            end else begin
                tree_q[access_index][2] <= ~access_way[0];
            end
        end
    end

endmodule

//--- hw/dcache_top.sv
// one request in compare at a time and memory must follow the req/rdy/return strobes
`timescale 1ns/1ns

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,
    // cpu side
    input  logic                  req_valid,
    input  dcache_pkg::mem_op_t   req_op,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::word_t     req_wdata,
    input  dcache_pkg::wstrb_t    req_wstrb,
    output logic                  busy,
    output logic                  done,
    output dcache_pkg::word_t     rdata,
    // memory read
    output logic                  mem_rd_req,
    output dcache_pkg::addr_t     mem_rd_addr,
    input  logic                  mem_rd_rdy,
    input  logic                  mem_ret_valid,
    input  dcache_pkg::line_t     mem_ret_data,
    // memory write
    output logic                  mem_wr_req,
    output dcache_pkg::addr_t     mem_wr_addr,
    output dcache_pkg::line_t     mem_wr_data,
    input  logic                  mem_wr_rdy,
    input  logic                  mem_wr_done
);
    import dcache_pkg::*;

    way_t                   way_valid;
    way_t                   way_dirty;
    tag_t  [ASSOC_NUM-1:0]  way_tags;
    line_t [ASSOC_NUM-1:0]  way_lines;
    way_idx_t               victim;
    index_t                 rd_index;
    index_t                 wr_index;
    way_t                   refill_we;
    tag_t                   refill_tag;
    line_t                  refill_line;
    way_t                   store_we;
    word_sel_t              store_word;
    word_t                  store_wdata;
    wstrb_t                 store_wstrb;
    index_t                 access_index;
    way_idx_t               access_way;
    logic                   access_en;

    dcache_ctrl ctrl_i (.*);  // request stage and miss FSM

    dcache_arrays arrays_i (
        .clk, .reset, .rd_index, .wr_index, .refill_we, .refill_tag, .refill_line,
        .store_we, .store_word, .store_wdata, .store_wstrb,
        .way_valid, .way_dirty, .way_tags, .way_lines
    );

    dcache_plru plru_i (
        .clk, .reset, .access_index, .access_way, .access_en, .victim
    );

endmodule

//--- sim.f
hw/dcache_pkg.sv
hw/dcache_arrays.sv
hw/dcache_plru.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/dcache_properties.sv
dv/dcache_tb.sv
